// File: memory_cache.f
+incdir+logic
logic/cache_pkg.sv
logic/cache_arrays.sv
logic/cache_control.sv
logic/line_fill.sv
logic/write_buffer.sv
logic/access_counters.sv
logic/memory_cache.sv
verification/tb_clock.sv
verification/axi_memory_model.sv
verification/memory_cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the cache testbench with verilator
verilator --binary --timing -f memory_cache.f --top-module memory_cache_tb \
   -o memory_cache_sim > build.log 2>&1 \
   && ./obj_dir/memory_cache_sim > sim.log 2>&1 \
   || { cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "All tests passed!" sim.log && exit 0 || exit 1

// File: verification/memory_cache_tb.sv
module memory_cache_tb
   import cache_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam word_t       fill_key     = 32'h5a17_c0de;
   localparam logic [31:0] lfsr_seed    = 32'd70575;
   localparam int          access_count = 30;
   localparam int          cycle_limit  = access_count * 200;

   typedef struct packed
   {
      logic [31:0] addr;
      word_t       data;
      strb_t       strb;
   } mem_write_t;

   logic        clk;
   logic        ctrl_reset;
   logic        cpu_valid;
   cpu_req_t    cpu_req;
   logic        cpu_ack;
   word_t       cpu_rdata;
   logic [1:0]  stat_addr;
   count_t      stat_data;
   axi_ar_t     ar;
   logic        ar_valid;
   logic        ar_ready;
   logic        r_valid;
   word_t       r_data;
   logic        r_last;
   logic        r_ready;
   logic [31:0] aw_addr;
   logic        aw_valid;
   logic        aw_ready;
   word_t       w_data;
   strb_t       w_strb;
   logic        w_valid;
   logic        w_ready;
   logic        b_valid;
   logic        b_ready;
   logic        wbuf_empty;
   logic        aw_hold;
   logic        ar_error;
   logic        wr_seen;
   logic [31:0] wr_addr;
   word_t       wr_data;
   strb_t       wr_strb;

   int          errors = 0;
   int          cycles = 0;
   int          test_no = 0;
   int          test_start_errors = 0;
   int          failing_tests = 0;
   logic [15:0] lfsr;
   mem_write_t  expq [$];      // cpu writes not yet seen at memory
   mem_write_t  exp_w;
   word_t       shadow [int];  // memory image of written words
   tag_t        known_tag [int];
   count_t      exp_count [3]; // hits, read misses, write misses

   tb_clock clock_i (.clk, .ctrl_reset);

   memory_cache dut_i (.*);

   axi_memory_model #(.fill_key(fill_key)) memory_i (
      .clk, .ctrl_reset, .ar, .ar_valid, .ar_ready, .r_valid, .r_data, .r_last, .r_ready,
      .aw_addr, .aw_valid, .aw_ready, .w_data, .w_strb, .w_valid, .w_ready, .b_valid,
      .aw_hold, .ar_error, .wr_seen, .wr_addr, .wr_data, .wr_strb
   );

   ////////////////////////////////////////
   // reference and helpers

   // 16 bit fibonacci lfsr with taps 16 14 13 11
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
         lfsr = {lfsr[14:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic word_t ref_word(input logic [29:0] wa);
      if (shadow.exists(int'(wa)))
         return shadow[int'(wa)];
      return {wa, 2'b00} ^ fill_key;
   endfunction

   function automatic word_t merge_bytes(input word_t old, input word_t nw, input strb_t s);
      word_t m;
      m = old;
      for (int b = 0; b < 4; b++)
         if (s[b])
            m[b*8 +: 8] = nw[b*8 +: 8];
      return m;
   endfunction

   function automatic count_t expected_count(input int sel);
      if (sel < 3)
         return exp_count[sel];
      return '0;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("FAIL %0t ns %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic begin_test();
      test_no++;
      test_start_errors = errors;
   endtask

   task automatic end_test(input string name);
      if (errors == test_start_errors)
         $display("test %0d %s: ok", test_no, name);
      else
      begin
         failing_tests++;
         $display("test %0d %s: %0d errors", test_no, name, errors - test_start_errors);
      end
   endtask

   // predicts the cache outcome and drives the request
   task automatic raise_request(input cpu_addr_t addr, input word_t data, input strb_t strb,
                                output word_t exp_rdata);
      logic [29:0] wa;
      logic        hit;
      mem_write_t  e;
      wa  = {2'b00, addr[29:2]};
      hit = known_tag.exists(int'(addr[12:3])) && known_tag[int'(addr[12:3])] == addr[29:13];
      exp_rdata = '0;
      if (strb != 4'h0)
      begin
         if (hit)
            exp_count[0]++;
         else
            exp_count[2]++;    // no allocate
         shadow[int'(wa)] = merge_bytes(ref_word(wa), data, strb);
         e.addr = {wa, 2'b00};
         e.data = data;
         e.strb = strb;
         expq.push_back(e);
      end
      else
      begin
         if (hit)
            exp_count[0]++;
         else
         begin
            exp_count[1]++;
            known_tag[int'(addr[12:3])] = addr[29:13];
         end
         exp_rdata = ref_word(wa);
      end
      cpu_req.addr  = addr;
      cpu_req.wdata = data;
      cpu_req.wstrb = strb;
      cpu_valid     = 1'b1;
   endtask

   task automatic wait_ack(output word_t rdata, output int lat);
      logic seen;
      seen = 1'b0;
      lat  = 0;
      while (!seen && lat < 200)
      begin
         @(posedge clk);
         #1;
         lat++;
         seen = cpu_ack;
      end
      if (!seen)
      begin
         $display("no cpu_ack within 200 cycles for address %h", cpu_req.addr);
         errors++;
      end
      rdata     = cpu_rdata;
      cpu_valid = 1'b0;
      @(posedge clk);    // one idle cycle between requests
      #1;
   endtask

   task automatic do_access(input cpu_addr_t addr, input word_t data, input strb_t strb,
                            input int exp_lat);
      word_t expd;
      word_t got;
      int    lat;
      raise_request(addr, data, strb, expd);
      wait_ack(got, lat);
      if (strb == 4'h0)
         check("cpu_rdata", got, expd);
      if (exp_lat > 0)
         check("ack latency", 32'(lat), 32'(exp_lat));
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (!wbuf_empty && n < 4000)
      begin
         @(posedge clk);
         #1;
         n++;
      end
      repeat (2) @(posedge clk);    // let the last write reach the monitor
      #1;
      check("wbuf_empty", 32'(wbuf_empty), 32'd1);
   endtask

   ////////////////////////////////////////
   // memory write monitor

   always @(negedge clk)
   begin
      if (wr_seen)
      begin
         if (expq.size() == 0)
         begin
            $display("memory write to %h with no matching cpu write", wr_addr);
            errors++;
         end
         else
         begin
            exp_w = expq.pop_front();
            check("aw_addr", wr_addr, exp_w.addr);
            check("w_data", wr_data, exp_w.data);
            check("w_strb", 32'(wr_strb), 32'(exp_w.strb));
         end
      end
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("timeout after %0d cycles", cycles);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////////////////////////
   // stimulus

   initial
   begin
      cpu_addr_t   a;
      cpu_addr_t   b;
      cpu_addr_t   c;
      word_t       d;
      word_t       got;
      strb_t       s;
      logic [31:0] r;
      int          lat;
      cpu_valid = 1'b0;
      cpu_req   = '0;
      stat_addr = 2'd0;
      aw_hold   = 1'b0;
      lfsr      = lfsr_seed[15:0];    // seed folded to 16 bits
      for (int i = 0; i < 3; i++)
         exp_count[i] = '0;
      #1;
      wait (!ctrl_reset);
      @(posedge clk);
      #1;

      begin_test();
      check("cpu_ack", 32'(cpu_ack), 32'd0);
      check("ar_valid", 32'(ar_valid), 32'd0);
      check("r_ready", 32'(r_ready), 32'd0);
      check("aw_valid", 32'(aw_valid), 32'd0);
      check("w_valid", 32'(w_valid), 32'd0);
      check("b_ready", 32'(b_ready), 32'd1);
      check("wbuf_empty", 32'(wbuf_empty), 32'd1);
      check("stat_data", stat_data, 32'd0);
      end_test("reset state");

      begin_test();
      r = rand_bits(27);
      a = {r[26:0], 1'b1, 2'b00};    // second word so the burst start must be realigned
      do_access(a, '0, 4'h0, 0);
      check("ar_error", 32'(ar_error), 32'd0);
      end_test("read miss");

      begin_test();
      do_access(a, '0, 4'h0, 3);
      do_access(a ^ 30'h4, '0, 4'h0, 3);    // other word of the line
      end_test("read hit");

      begin_test();
      r = rand_bits(4);
      s = r[3:0];
      if (s == 4'h0)
         s = 4'hf;
      d = rand_bits(32);
      do_access(a, d, s, 2);
      do_access(a, '0, 4'h0, 0);
      wait_drain();
      end_test("write hit");

      begin_test();
      b = a ^ 30'h2000;    // same index with another tag
      d = rand_bits(32);
      do_access(b, d, 4'hf, 2);
      wait_drain();
      do_access(b, '0, 4'h0, 0);
      stat_addr = 2'd1;
      @(posedge clk);
      #1;
      check("stat_data", stat_data, 32'd2);
      check("ar_error", 32'(ar_error), 32'd0);
      end_test("write miss");

      begin_test();
      aw_hold = 1'b1;
      for (int i = 0; i < 17; i++)
      begin
         r = rand_bits(28);
         c = {r[27:0], 2'b00};
         r = rand_bits(4);
         s = (r[3:0] == 4'h0) ? 4'hf : r[3:0];
         d = rand_bits(32);
         if (i < 16)
            do_access(c, d, s, 0);
         else
         begin
            raise_request(c, d, s, got);
            repeat (20)
            begin
               @(posedge clk);
               #1;
               check("cpu_ack", 32'(cpu_ack), 32'd0);    // buffer is full
            end
            aw_hold = 1'b0;
            wait_ack(got, lat);
         end
      end
      wait_drain();
      check("pending writes", 32'(expq.size()), 32'd0);
      end_test("write buffer full");

      begin_test();
      for (int i = 0; i < 4; i++)
      begin
         stat_addr = 2'(i);
         @(posedge clk);
         #1;
         check("stat_data", stat_data, expected_count(i));
      end
      end_test("statistics");

      $display("tests: %0d, failing tests: %0d, failed checks: %0d",
               test_no, failing_tests, errors);
      if (errors == 0 && expq.size() == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// File: verification/axi_memory_model.sv
module axi_memory_model
   import cache_pkg::*;
#(
   parameter word_t fill_key = 32'h5a17_c0de
)
(
   input  logic        clk,
   input  logic        ctrl_reset,
   input  axi_ar_t     ar,
   input  logic        ar_valid,
   output logic        ar_ready,
   output logic        r_valid,
   output word_t       r_data,
   output logic        r_last,
   input  logic        r_ready,
   input  logic [31:0] aw_addr,
   input  logic        aw_valid,
   output logic        aw_ready,
   input  word_t       w_data,
   input  strb_t       w_strb,
   input  logic        w_valid,
   output logic        w_ready,
   output logic        b_valid,
   input  logic        aw_hold,     // stalls the address phase
   output logic        ar_error,
   output logic        wr_seen,
   output logic [31:0] wr_addr,
   output word_t       wr_data,
   output strb_t       wr_strb
);

   timeunit 1ns;
   timeprecision 1ps;

   word_t       mem [int];    // only written words are stored
   logic [29:0] rd_wa;        // word address of the next read beat
   logic [29:0] wr_wa;
   word_t       merged;

   // untouched words hold their own address mixed with a key
   function automatic word_t read_word(input logic [29:0] wa);
      if (mem.exists(int'(wa)))
         return mem[int'(wa)];
      return {wa, 2'b00} ^ fill_key;
   endfunction

   assign ar_ready = !r_valid;
   assign aw_ready = !aw_hold;
   assign w_ready  = 1'b1;

   always @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         r_valid  <= 1'b0;
         r_last   <= 1'b0;
         r_data   <= '0;
         rd_wa    <= '0;
         wr_wa    <= '0;
         ar_error <= 1'b0;
         wr_seen  <= 1'b0;
         wr_addr  <= '0;
         wr_data  <= '0;
         wr_strb  <= '0;
         b_valid  <= 1'b0;
      end
      else
      begin
         wr_seen <= 1'b0;
         b_valid <= 1'b0;

         ////////////////////////////////////////
         // read burst
         if (ar_valid && ar_ready)
         begin
            if (ar.addr[2:0] != 3'd0 || ar.len != 8'd1 || ar.size != 3'd2
                || ar.burst != 2'd1)
               ar_error <= 1'b1;    // sticky
            r_valid <= 1'b1;
            r_data  <= read_word(ar.addr[31:2]);
            r_last  <= (ar.len == 8'd0);
            rd_wa   <= ar.addr[31:2] + 30'd1;
         end
         else if (r_valid && r_ready)
         begin
            if (r_last)
               r_valid <= 1'b0;
            else
            begin
               r_data <= read_word(rd_wa);
               r_last <= 1'b1;
               rd_wa  <= rd_wa + 30'd1;
            end
         end

         ////////////////////////////////////////
         // write address then data
         if (aw_valid && aw_ready)
            wr_wa <= aw_addr[31:2];
         if (w_valid && w_ready)
         begin
            merged = read_word(wr_wa);
            for (int b = 0; b < 4; b++)
               if (w_strb[b])
                  merged[b*8 +: 8] = w_data[b*8 +: 8];
            mem[int'(wr_wa)] = merged;
            wr_seen <= 1'b1;
            wr_addr <= {wr_wa, 2'b00};
            wr_data <= w_data;
            wr_strb <= w_strb;
            b_valid <= 1'b1;
         end
      end
   end

endmodule

// File: verification/tb_clock.sv
module tb_clock
(
   output logic clk,
   output logic ctrl_reset
);

   timeunit 1ns;
   timeprecision 1ps;

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;    // 10 ns period
   end

   initial
   begin
      ctrl_reset = 1'b1;
      repeat (10) @(posedge clk);
      #1 ctrl_reset = 1'b0;
   end

endmodule

// File: logic/memory_cache.sv
`include "cache_settings.svh"

module memory_cache
   import cache_pkg::*;
(
   input  logic                         clk,
   input  logic                         ctrl_reset,
   input  logic                         cpu_valid,
   input  cpu_req_t                     cpu_req,
   output logic                         cpu_ack,
   output word_t                        cpu_rdata,
   input  logic [1:0]                   stat_addr,
   output count_t                       stat_data,
   output axi_ar_t                      ar,
   output logic                         ar_valid,
   input  logic                         ar_ready,
   input  logic                         r_valid,
   input  word_t                        r_data,
   input  logic                         r_last,
   output logic                         r_ready,
   output logic [`CACHE_AXI_ADDR_W-1:0] aw_addr,
   output logic                         aw_valid,
   input  logic                         aw_ready,
   output word_t                        w_data,
   output strb_t                        w_strb,
   output logic                         w_valid,
   input  logic                         w_ready,
   input  logic                         b_valid,    // write responses are ignored
   output logic                         b_ready,
   output logic                         wbuf_empty
);

   index_t      arr_index;
   word_sel_t   arr_word_sel;
   strb_t       arr_wstrb;
   word_t       arr_wdata;
   tag_t        arr_tag;
   logic        arr_valid;
   word_t       arr_rdata;
   logic        fill_start;
   logic        fill_busy;
   logic        fill_we;
   word_sel_t   fill_sel;
   word_t       fill_data;
   logic        fill_tag_we;
   tag_t        fill_tag;
   logic        buf_push;
   wbuf_entry_t buf_entry;
   logic        buf_full;
   logic        hit_evt;
   logic        read_miss_evt;
   logic        write_miss_evt;

   cache_control control_i (
      .clk, .ctrl_reset, .cpu_valid, .cpu_req, .cpu_ack, .cpu_rdata,
      .index     (arr_index),
      .word_sel  (arr_word_sel),
      .cpu_wstrb (arr_wstrb),
      .cpu_wdata (arr_wdata),
      .tag       (arr_tag),
      .valid     (arr_valid),
      .rdata     (arr_rdata),
      .fill_start, .fill_busy, .buf_push, .buf_entry, .buf_full,
      .hit_evt, .read_miss_evt, .write_miss_evt
   );

   cache_arrays arrays_i (
      .clk, .ctrl_reset,
      .index     (arr_index),
      .word_sel  (arr_word_sel),
      .cpu_wstrb (arr_wstrb),
      .cpu_wdata (arr_wdata),
      .fill_we, .fill_sel, .fill_data, .fill_tag_we, .fill_tag,
      .tag       (arr_tag),
      .valid     (arr_valid),
      .rdata     (arr_rdata)
   );

   // fill uses the held cpu address for the line
   line_fill fill_i (
      .clk, .ctrl_reset, .fill_start,
      .line_addr (cpu_req.addr),
      .fill_busy, .ar, .ar_valid, .ar_ready, .r_valid, .r_data, .r_last, .r_ready,
      .fill_we, .fill_sel, .fill_data, .fill_tag_we, .fill_tag
   );

   write_buffer wbuf_i (
      .clk, .ctrl_reset, .buf_push, .buf_entry, .buf_full, .wbuf_empty,
      .aw_addr, .aw_valid, .aw_ready, .w_data, .w_strb, .w_valid, .w_ready, .b_ready
   );

   access_counters counters_i (
      .clk, .ctrl_reset, .hit_evt, .read_miss_evt, .write_miss_evt,
      .stat_addr, .stat_data
   );

endmodule

// File: logic/access_counters.sv
module access_counters
   import cache_pkg::*;
(
   input  logic       clk,
   input  logic       ctrl_reset,
   input  logic       hit_evt,
   input  logic       read_miss_evt,
   input  logic       write_miss_evt,
   input  logic [1:0] stat_addr,
   output count_t     stat_data
);

   count_t     counts [3];    // hits, read misses, write misses
   logic [2:0] evts;

   assign evts = {write_miss_evt, read_miss_evt, hit_evt};

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         for (int i = 0; i < 3; i++)
            counts[i] <= '0;
      end
      else
      begin
         for (int i = 0; i < 3; i++)
            if (evts[i])
               counts[i] <= counts[i] + 1'b1;
      end
   end

   // readout one clock after the select
   always_ff @(posedge clk)
   begin
      case (stat_addr)
         2'd0:    stat_data <= counts[0];
         2'd1:    stat_data <= counts[1];
         2'd2:    stat_data <= counts[2];
         default: stat_data <= '0;
      endcase
   end

endmodule

// File: logic/write_buffer.sv
`include "cache_settings.svh"

module write_buffer
   import cache_pkg::*;
(
   input  logic                         clk,
   input  logic                         ctrl_reset,
   input  logic                         buf_push,
   input  wbuf_entry_t                  buf_entry,
   output logic                         buf_full,
   output logic                         wbuf_empty,
   output logic [`CACHE_AXI_ADDR_W-1:0] aw_addr,
   output logic                         aw_valid,
   input  logic                         aw_ready,
   output word_t                        w_data,
   output strb_t                        w_strb,
   output logic                         w_valid,
   input  logic                         w_ready,
   output logic                         b_ready
);

   localparam int depth = 2**`CACHE_BUF_DEPTH_W;

   typedef logic [`CACHE_BUF_DEPTH_W:0] ptr_t;    // extra wrap bit

   wbuf_entry_t fifo_mem [depth];
   wbuf_entry_t head;
   ptr_t        wr_ptr;
   ptr_t        rd_ptr;
   wbuf_state_t state;
   logic        pop;

   // head stays in place until its data phase completes
   assign head       = fifo_mem[rd_ptr[`CACHE_BUF_DEPTH_W-1:0]];
   assign wbuf_empty = (wr_ptr == rd_ptr);
   assign buf_full   = (wr_ptr ^ rd_ptr) == {1'b1, {`CACHE_BUF_DEPTH_W{1'b0}}};
   assign pop        = (state == wbuf_data) && w_ready;

   assign aw_addr = {{(`CACHE_AXI_ADDR_W-`CACHE_ADDR_W){1'b0}}, head.addr, {wsel_lo{1'b0}}};
   assign w_data  = head.data;
   assign w_strb  = head.strb;
   assign b_ready = 1'b1;    // responses are not tracked

   always_ff @(posedge clk)
   begin
      if (buf_push && !buf_full)
         fifo_mem[wr_ptr[`CACHE_BUF_DEPTH_W-1:0]] <= buf_entry;
   end

   ////////////////////////////////////////
   // pointers and axi write fsm

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         state    <= wbuf_idle;
         aw_valid <= 1'b0;
         w_valid  <= 1'b0;
      end
      else
      begin
         if (buf_push && !buf_full)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case (state)
            wbuf_idle:
               if (!wbuf_empty)
               begin
                  aw_valid <= 1'b1;
                  state    <= wbuf_addr;
               end
            wbuf_addr:
               if (aw_ready)
               begin
                  aw_valid <= 1'b0;
                  w_valid  <= 1'b1;    // data phase follows the address
                  state    <= wbuf_data;
               end
            default:
               if (w_ready)
               begin
                  w_valid <= 1'b0;
                  state   <= wbuf_idle;
               end
         endcase
      end
   end

endmodule

// File: logic/line_fill.sv
`include "cache_settings.svh"

module line_fill
   import cache_pkg::*;
(
   input  logic      clk,
   input  logic      ctrl_reset,
   input  logic      fill_start,
   input  cpu_addr_t line_addr,
   output logic      fill_busy,
   output axi_ar_t   ar,
   output logic      ar_valid,
   input  logic      ar_ready,
   input  logic      r_valid,
   input  word_t     r_data,
   input  logic      r_last,
   output logic      r_ready,
   output logic      fill_we,
   output word_sel_t fill_sel,
   output word_t     fill_data,
   output logic      fill_tag_we,
   output tag_t      fill_tag
);

   localparam int beats = 2**`CACHE_WSEL_W;

   fill_state_t state;
   word_sel_t   beat;    // bank for the next beat

   assign fill_busy   = (state != fill_idle);
   assign fill_we     = (state == fill_beats) && r_valid && r_ready;
   assign fill_sel    = beat;
   assign fill_data   = r_data;
   assign fill_tag_we = fill_we && r_last;
   assign fill_tag    = line_addr[tag_lo +: tag_w];

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         state    <= fill_idle;
         ar_valid <= 1'b0;
         r_ready  <= 1'b0;
         beat     <= '0;
      end
      else
         case (state)
            fill_idle:
               if (fill_start)
               begin
                  ar_valid <= 1'b1;
                  beat     <= '0;
                  state    <= fill_addr;
               end
            fill_addr:
               if (ar_ready)
               begin
                  ar_valid <= 1'b0;
                  r_ready  <= 1'b1;
                  state    <= fill_beats;
               end
            default:
               if (fill_we)
               begin
                  beat <= beat + 1'b1;
                  if (r_last)
                  begin
                     r_ready <= 1'b0;
                     state   <= fill_idle;
                  end
               end
         endcase
   end

   // line aligned incr burst of 4 byte beats
   always_ff @(posedge clk)
   begin
      if (state == fill_idle && fill_start)
      begin
         ar.addr  <= {{(`CACHE_AXI_ADDR_W-`CACHE_ADDR_W){1'b0}},
                      line_addr[`CACHE_ADDR_W-1:index_lo], {index_lo{1'b0}}};
         ar.len   <= `CACHE_AXI_LEN_W'(beats - 1);
         ar.size  <= 3'b010;
         ar.burst <= 2'b01;
      end
   end

endmodule

// File: logic/cache_control.sv
`include "cache_settings.svh"

module cache_control
   import cache_pkg::*;
(
   input  logic        clk,
   input  logic        ctrl_reset,
   input  logic        cpu_valid,
   input  cpu_req_t    cpu_req,
   output logic        cpu_ack,
   output word_t       cpu_rdata,
   output index_t      index,
   output word_sel_t   word_sel,
   output strb_t       cpu_wstrb,
   output word_t       cpu_wdata,
   input  tag_t        tag,
   input  logic        valid,
   input  word_t       rdata,
   output logic        fill_start,
   input  logic        fill_busy,
   output logic        buf_push,
   output wbuf_entry_t buf_entry,
   input  logic        buf_full,
   output logic        hit_evt,
   output logic        read_miss_evt,
   output logic        write_miss_evt
);

   ctrl_state_t state;
   logic        is_write;
   logic        hit;
   logic        lookup;

   ////////////////////////////////////////
   // lookup

   assign index    = cpu_req.addr[index_lo +: $bits(index_t)];
   assign word_sel = cpu_req.addr[wsel_lo +: $bits(word_sel_t)];
   assign is_write = |cpu_req.wstrb;
   assign hit      = valid && (tag == cpu_req.addr[tag_lo +: tag_w]);
   assign lookup   = (state == ctrl_compare);

   assign hit_evt        = lookup && hit;
   assign read_miss_evt  = lookup && !hit && !is_write;
   assign write_miss_evt = lookup && !hit && is_write;
   assign fill_start     = read_miss_evt;

   // only a write hit updates the array
   assign cpu_wstrb = hit_evt ? cpu_req.wstrb : '0;
   assign cpu_wdata = cpu_req.wdata;

   ////////////////////////////////////////
   // write-through

   assign buf_push       = is_write && !buf_full
                           && (lookup || state == ctrl_write_wait);
   assign buf_entry.strb = cpu_req.wstrb;
   assign buf_entry.addr = cpu_req.addr[`CACHE_ADDR_W-1:wsel_lo];
   assign buf_entry.data = cpu_req.wdata;

   ////////////////////////////////////////
   // access fsm

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         state   <= ctrl_idle;
         cpu_ack <= 1'b0;
      end
      else
      begin
         cpu_ack <= 1'b0;    // single cycle pulse
         case (state)
            ctrl_idle:
               if (cpu_valid)
                  state <= ctrl_compare;
            ctrl_compare, ctrl_write_wait:
               if (is_write)
               begin
                  if (buf_full)
                     state <= ctrl_write_wait;    // hold cpu until a slot frees
                  else
                  begin
                     cpu_ack <= 1'b1;
                     state   <= ctrl_gap;
                  end
               end
               else if (hit)
                  state <= ctrl_hit;
               else
                  state <= ctrl_fill_wait;
            ctrl_fill_wait:
               if (!fill_busy)
                  state <= ctrl_reread;
            ctrl_reread:
               state <= ctrl_hit;    // array read of the new line
            ctrl_hit:
            begin
               cpu_ack <= 1'b1;
               state   <= ctrl_gap;
            end
            default:
               state <= ctrl_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (state == ctrl_hit)
         cpu_rdata <= rdata;
   end

endmodule

// File: logic/cache_arrays.sv
`include "cache_settings.svh"

module cache_arrays
   import cache_pkg::*;
(
   input  logic      clk,
   input  logic      ctrl_reset,
   input  index_t    index,
   input  word_sel_t word_sel,
   input  strb_t     cpu_wstrb,
   input  word_t     cpu_wdata,
   input  logic      fill_we,
   input  word_sel_t fill_sel,
   input  word_t     fill_data,
   input  logic      fill_tag_we,
   input  tag_t      fill_tag,
   output tag_t      tag,
   output logic      valid,
   output word_t     rdata
);

   localparam int words = 2**`CACHE_WSEL_W;
   localparam int lines = 2**`CACHE_INDEX_W;
   localparam int bytes = $bits(strb_t);

   word_t            data_mem [words][lines];   // one bank per word of the line
   tag_t             tag_mem [lines];
   logic [lines-1:0] valid_bits;
   strb_t            bank_strb [words];
   word_t            wdata;

   // fill beat wins over a cpu write
   assign wdata = fill_we ? fill_data : cpu_wdata;

   always_comb
   begin
      for (int w = 0; w < words; w++)
      begin
         if (fill_we)
            bank_strb[w] = (fill_sel == word_sel_t'(w)) ? '1 : '0;
         else
            bank_strb[w] = (word_sel == word_sel_t'(w)) ? cpu_wstrb : '0;
      end
   end

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < words; w++)
         for (int b = 0; b < bytes; b++)
            if (bank_strb[w][b])
               data_mem[w][index][b*8 +: 8] <= wdata[b*8 +: 8];
      if (fill_tag_we)
         tag_mem[index] <= fill_tag;
      rdata <= data_mem[word_sel][index];    // registered read
      tag   <= tag_mem[index];
   end

   always_ff @(posedge clk or posedge ctrl_reset)
   begin
      if (ctrl_reset)
      begin
         valid_bits <= '0;
         valid      <= 1'b0;
      end
      else
      begin
         if (fill_tag_we)
            valid_bits[index] <= 1'b1;    // line complete
         valid <= valid_bits[index];
      end
   end

endmodule

// File: logic/cache_pkg.sv
package cache_pkg;
`include "cache_settings.svh"

   // address field positions with the tag in the remaining bits
   localparam int wsel_lo  = `CACHE_BYTE_OFS_W;
   localparam int index_lo = wsel_lo + `CACHE_WSEL_W;
   localparam int tag_lo   = index_lo + `CACHE_INDEX_W;
   localparam int tag_w    = `CACHE_ADDR_W - tag_lo;

   typedef logic [`CACHE_WORD_W-1:0]           word_t;
   typedef logic [`CACHE_WORD_W/8-1:0]         strb_t;
   typedef logic [`CACHE_ADDR_W-1:0]           cpu_addr_t;
   typedef logic [tag_w-1:0]                   tag_t;
   typedef logic [`CACHE_INDEX_W-1:0]          index_t;
   typedef logic [`CACHE_WSEL_W-1:0]           word_sel_t;
   typedef logic [`CACHE_COUNT_W-1:0]          count_t;
   typedef logic [`CACHE_ADDR_W-wsel_lo-1:0]   word_addr_t;

   typedef struct packed
   {
      cpu_addr_t addr;
      word_t     wdata;
      strb_t     wstrb;    // all zero for a read
   } cpu_req_t;

   typedef struct packed
   {
      strb_t      strb;
      word_addr_t addr;
      word_t      data;
   } wbuf_entry_t;

   typedef struct packed
   {
      logic [`CACHE_AXI_ADDR_W-1:0]  addr;
      logic [`CACHE_AXI_LEN_W-1:0]   len;
      logic [`CACHE_AXI_SIZE_W-1:0]  size;
      logic [`CACHE_AXI_BURST_W-1:0] burst;
   } axi_ar_t;

   typedef enum logic [2:0]
   {
      ctrl_idle,
      ctrl_compare,
      ctrl_write_wait,
      ctrl_fill_wait,
      ctrl_reread,
      ctrl_hit,
      ctrl_gap
   } ctrl_state_t;

   typedef enum logic [1:0] {fill_idle, fill_addr, fill_beats} fill_state_t;
   typedef enum logic [1:0] {wbuf_idle, wbuf_addr, wbuf_data} wbuf_state_t;

endpackage

// File: logic/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

////////////////////////////////////////
// cpu side

`define CACHE_ADDR_W       30    // word-byte address without the memory select bits
`define CACHE_WORD_W       32
`define CACHE_BYTE_OFS_W   2     // byte within a word
`define CACHE_INDEX_W      10
`define CACHE_WSEL_W       1     // two words per line
`define CACHE_BUF_DEPTH_W  4     // 16 write buffer entries
`define CACHE_COUNT_W      32

////////////////////////////////////////
// axi side

`define CACHE_AXI_ADDR_W   32
`define CACHE_AXI_LEN_W    8
`define CACHE_AXI_SIZE_W   3
`define CACHE_AXI_BURST_W  2

`endif
